// ==== hw/mazePkg.sv ====
`default_nettype none

package mazePkg;

    // Stack depth counter, enough for 50 entries
    localparam int depthWidth = 6;

    typedef enum logic [3:0] {
        IDLE,
        START,
        COUNT,
        STRAIGHT,
        LITTLE_LEFT,
        LITTLE_RIGHT,
        CHOOSE,
        LEFT,
        RIGHT,
        BACK,
        STOP,
        FINISH
    } navState_t;

    // Sensor pattern in left, mid, right order
    typedef enum logic [2:0] {
        ERROR_ROAD    = 3'b000,
        RIGHT_LITTLE  = 3'b001,
        STRAIGHT_ROAD = 3'b010,
        RIGHT_ROAD    = 3'b011,
        LEFT_LITTLE   = 3'b100,
        TURN101       = 3'b101,
        LEFT_ROAD     = 3'b110,
        TURN111       = 3'b111
    } road_t;

    // Choice taken at a junction
    typedef enum logic [1:0] {
        NONE         = 2'd0,
        DEC_STRAIGHT = 2'd1,
        DEC_LEFT     = 2'd2,
        DEC_RIGHT    = 2'd3
    } decision_t;

    typedef enum logic [2:0] {
        HALT,
        FORWARD,
        VEER_LEFT,
        VEER_RIGHT,
        SPIN_LEFT,
        SPIN_RIGHT,
        REVERSE
    } driveCmd_t;

endpackage

`default_nettype wire

// ==== hw/stackIf.sv ====
`default_nettype none

interface stackIf;
    import mazePkg::*;

    logic                  push;
    logic                  replace;
    decision_t             pushValue;
    decision_t             top;
    logic [depthWidth-1:0] depth;

    // Navigator side issues requests
    modport nav (
        output push, replace, pushValue,
        input  top, depth
    );

    modport store (
        input  push, replace, pushValue,
        output top, depth
    );

endinterface

`default_nettype wire

// ==== hw/trackDecoder.sv ====
`default_nettype none

module trackDecoder (
    input  logic           clk,
    input  logic           rst,
    input  logic           leftTrack,
    input  logic           midTrack,
    input  logic           rightTrack,
    output mazePkg::road_t road
);
    import mazePkg::*;

    logic [2:0] syncMeta;
    logic [2:0] syncTrack;

    // Sensors are asynchronous to clk
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            syncMeta  <= 3'b000;
            syncTrack <= 3'b000;
        end else begin
            syncMeta  <= {leftTrack, midTrack, rightTrack};
            syncTrack <= syncMeta;
        end
    end

    always_comb begin
        case (syncTrack)
            3'b001:  road = RIGHT_LITTLE;
            3'b010:  road = STRAIGHT_ROAD;
            3'b011:  road = RIGHT_ROAD;
            3'b100:  road = LEFT_LITTLE;
            3'b101:  road = TURN101;
            3'b110:  road = LEFT_ROAD;
            3'b111:  road = TURN111;
            default: road = ERROR_ROAD;
        endcase
    end

    // An undriven sensor pin would reach the FSM here
    trackKnown: assert property (
        @(posedge clk) disable iff (rst)
        !$isunknown(syncTrack)
    ) else $error("trackDecoder: synchronized sensor pattern is unknown");

endmodule

`default_nettype wire

// ==== hw/waitTimer.sv ====
`default_nettype none

module waitTimer #(
    parameter int countCycles = 30,
    parameter int stopCycles  = 20
) (
    input  logic clk,
    input  logic rst,
    input  logic timerRun,
    input  logic timerLong,
    output logic timerDone
);
    localparam int maxCycles = (countCycles > stopCycles) ? countCycles : stopCycles;
    localparam int cntWidth  = $clog2(maxCycles + 1);

    logic                running;
    logic [cntWidth-1:0] remaining;
    logic [cntWidth-1:0] loadValue;

    // First count edge is the load itself
    assign loadValue = timerLong ? cntWidth'(countCycles - 1) : cntWidth'(stopCycles - 1);

    // Gated by timerRun so a finished interval never leaks into the next state
    assign timerDone = timerRun && running && (remaining == '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            running   <= 1'b0;
            remaining <= '0;
        end else if (!timerRun) begin
            running   <= 1'b0;
            remaining <= '0;
        end else if (!running) begin
            running   <= 1'b1;
            remaining <= loadValue;
        end else if (remaining != '0) begin
            remaining <= remaining - 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== hw/mazeNavigator.sv ====
`default_nettype none

module mazeNavigator (
    input  logic               clk,
    input  logic               rst,
    input  logic               enable,
    input  logic               obstacleNear,
    input  mazePkg::road_t     road,
    input  logic               timerDone,
    output logic               timerRun,
    output logic               timerLong,
    stackIf.nav                stk,
    output mazePkg::driveCmd_t driveCmd,
    output mazePkg::navState_t navState
);
    import mazePkg::*;

    navState_t state;
    navState_t nextState;
    navState_t prevState;
    navState_t resumeState;
    navState_t nextResume;
    logic      armed;
    logic      reqPush;
    logic      reqReplace;
    decision_t reqValue;
    logic      pushQ;
    logic      replaceQ;
    decision_t valueQ;

    assign navState      = state;
    assign timerRun      = (state == COUNT) || (state == STOP);
    assign timerLong     = (state == COUNT);
    assign stk.push      = pushQ;
    assign stk.replace   = replaceQ;
    assign stk.pushValue = valueQ;

    always_comb begin
        nextState  = state;
        nextResume = resumeState;
        reqPush    = 1'b0;
        reqReplace = 1'b0;
        reqValue   = NONE;
        if (!enable) begin
            nextState = IDLE;
        end else if (obstacleNear) begin
            nextState = FINISH;
        end else begin
            case (state)
                IDLE: nextState = START;
                START: begin
                    if (road == STRAIGHT_ROAD) begin
                        nextState = COUNT;
                    end
                end
                COUNT: begin
                    if (timerDone) begin
                        nextState = STRAIGHT;
                    end
                end
                STRAIGHT, LITTLE_LEFT, LITTLE_RIGHT: begin
                    case (road)
                        ERROR_ROAD: begin
                            nextState  = STOP;
                            nextResume = BACK;
                        end
                        RIGHT_ROAD, RIGHT_LITTLE: nextState = LITTLE_RIGHT;
                        LEFT_ROAD, LEFT_LITTLE:   nextState = LITTLE_LEFT;
                        TURN111: begin
                            // New junction, try straight first
                            if (armed) begin
                                nextState = CHOOSE;
                                reqPush   = 1'b1;
                                reqValue  = DEC_STRAIGHT;
                            end else begin
                                nextState = STRAIGHT;
                            end
                        end
                        default: nextState = STRAIGHT;
                    endcase
                end
                CHOOSE: begin
                    if (road == TURN101) begin
                        nextState  = STOP;
                        nextResume = LEFT;
                        reqReplace = 1'b1;
                        reqValue   = DEC_LEFT;
                    end else if (road == TURN111 && armed) begin
                        nextState = STRAIGHT;
                    end
                end
                LEFT: begin
                    if (armed && road == TURN101) begin
                        nextState  = STOP;
                        nextResume = RIGHT;
                        reqReplace = 1'b1;
                        reqValue   = DEC_RIGHT;
                    end else if (armed && road == TURN111) begin
                        nextState  = STOP;
                        nextResume = STRAIGHT;
                    end
                end
                RIGHT: begin
                    if (armed && road == TURN111) begin
                        nextState  = STOP;
                        nextResume = STRAIGHT;
                    end
                end
                BACK: begin
                    // Back at the junction, take the next untried branch
                    if (road == TURN111) begin
                        nextState = STOP;
                        case (stk.top)
                            DEC_STRAIGHT: begin
                                nextResume = LEFT;
                                reqReplace = 1'b1;
                                reqValue   = DEC_LEFT;
                            end
                            DEC_LEFT: begin
                                nextResume = RIGHT;
                                reqReplace = 1'b1;
                                reqValue   = DEC_RIGHT;
                            end
                            default: nextResume = BACK;
                        endcase
                    end
                end
                STOP: begin
                    if (timerDone) begin
                        nextState = resumeState;
                    end
                end
                default: nextState = state;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= IDLE;
            prevState   <= IDLE;
            resumeState <= IDLE;
            armed       <= 1'b0;
            pushQ       <= 1'b0;
            replaceQ    <= 1'b0;
        end else begin
            state       <= nextState;
            resumeState <= nextResume;
            pushQ       <= reqPush;
            replaceQ    <= reqReplace;
            // Arming keeps a junction pattern from firing twice in one state
            if (nextState != state) begin
                prevState <= state;
                armed     <= 1'b0;
            end else if (road != TURN111 || (state == STRAIGHT && prevState == COUNT)) begin
                armed <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        valueQ <= reqValue;
    end

    always_comb begin
        case (state)
            STRAIGHT:     driveCmd = FORWARD;
            LITTLE_LEFT:  driveCmd = VEER_LEFT;
            LITTLE_RIGHT: driveCmd = VEER_RIGHT;
            LEFT:         driveCmd = SPIN_LEFT;
            RIGHT:        driveCmd = SPIN_RIGHT;
            BACK:         driveCmd = REVERSE;
            default:      driveCmd = HALT;
        endcase
    end

    reqExclusive: assert property (
        @(posedge clk) disable iff (rst)
        !(stk.push && stk.replace)
    ) else $error("mazeNavigator: push and replace in the same cycle");

    doneInTimedState: assert property (
        @(posedge clk) disable iff (rst)
        timerDone |-> (state == COUNT || state == STOP)
    ) else $error("mazeNavigator: timerDone outside COUNT or STOP");

endmodule

`default_nettype wire

// ==== hw/decisionStack.sv ====
`default_nettype none

module decisionStack #(
    parameter int stackDepth = 50
) (
    input logic   clk,
    input logic   rst,
    stackIf.store stk
);
    import mazePkg::*;

    localparam logic [depthWidth-1:0] fullCount = depthWidth'(stackDepth);

    decision_t             mem [stackDepth];
    logic [depthWidth-1:0] count;
    logic [depthWidth-1:0] topIndex;
    logic [depthWidth-1:0] replaceIndex;
    logic                  doPush;

    assign topIndex     = count - 1'b1;
    assign replaceIndex = (count == '0) ? '0 : topIndex;
    // Full stack drops the push
    assign doPush       = stk.push && (count < fullCount);

    assign stk.depth = count;
    assign stk.top   = (count == '0) ? NONE : mem[topIndex];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count <= '0;
        end else if (doPush) begin
            count <= count + 1'b1;
        end else if (stk.replace && count == '0) begin
            count <= depthWidth'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (doPush) begin
            mem[count] <= stk.pushValue;
        end else if (stk.replace) begin
            mem[replaceIndex] <= stk.pushValue;
        end
    end

    depthBound: assert property (
        @(posedge clk) disable iff (rst)
        stk.depth <= fullCount
    ) else $error("decisionStack: depth beyond capacity");

endmodule

`default_nettype wire

// ==== hw/mazeController.sv ====
`default_nettype none

module mazeController #(
    parameter int countCycles = 30,
    parameter int stopCycles  = 20,
    parameter int stackSize   = 50
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             enable,
    input  logic                             leftTrack,
    input  logic                             midTrack,
    input  logic                             rightTrack,
    input  logic                             obstacleNear,
    output mazePkg::driveCmd_t               driveCmd,
    output mazePkg::navState_t               navState,
    output logic [mazePkg::depthWidth-1:0]   stackDepth,
    output mazePkg::decision_t               stackTop
);
    import mazePkg::*;

    road_t road;
    logic  timerRun;
    logic  timerLong;
    logic  timerDone;

    stackIf stk ();

    trackDecoder u_trackDecoder (
        .clk        (clk),
        .rst        (rst),
        .leftTrack  (leftTrack),
        .midTrack   (midTrack),
        .rightTrack (rightTrack),
        .road       (road)
    );

    // Launch and pause intervals share one counter
    waitTimer #(
        .countCycles (countCycles),
        .stopCycles  (stopCycles)
    ) u_waitTimer (
        .clk       (clk),
        .rst       (rst),
        .timerRun  (timerRun),
        .timerLong (timerLong),
        .timerDone (timerDone)
    );

    mazeNavigator u_mazeNavigator (
        .clk          (clk),
        .rst          (rst),
        .enable       (enable),
        .obstacleNear (obstacleNear),
        .road         (road),
        .timerDone    (timerDone),
        .timerRun     (timerRun),
        .timerLong    (timerLong),
        .stk          (stk.nav),
        .driveCmd     (driveCmd),
        .navState     (navState)
    );

    decisionStack #(
        .stackDepth (stackSize)
    ) u_decisionStack (
        .clk (clk),
        .rst (rst),
        .stk (stk.store)
    );

    assign stackDepth = stk.depth;
    assign stackTop   = stk.top;

endmodule

`default_nettype wire

// ==== tests/mazeControllerTests.svh ====
`ifndef MAZE_CONTROLLER_TESTS_SVH
`define MAZE_CONTROLLER_TESTS_SVH

task automatic resetTest();
    int errorsBefore;
    errorsBefore = errorCount;
    checkNav(IDLE, HALT);
    checkStack(0, NONE);
    reportTest("resetTest", errorsBefore);
endtask

task automatic launchTest();
    int errorsBefore;
    int stay;
    errorsBefore = errorCount;
    @(posedge clk);
    enable     <= 1'b1;
    leftTrack  <= 1'b0;
    midTrack   <= 1'b1;
    rightTrack <= 1'b0;
    waitForState(COUNT, 10);
    measureStay(COUNT, stay);
    if (stay != countCycles + 1) begin
        $display("FAILED at %0t ns: navState held COUNT for %0d cycles, expected %0d",
                 $time, stay, countCycles + 1);
        errorCount++;
    end
    checkNav(STRAIGHT, FORWARD);
    checkStack(0, NONE);
    reportTest("launchTest", errorsBefore);
endtask

task automatic driftTest();
    int errorsBefore;
    errorsBefore = errorCount;
    setSensors(1'b1, 1'b1, 1'b0);
    checkNav(LITTLE_LEFT, VEER_LEFT);
    setSensors(1'b0, 1'b1, 1'b1);
    checkNav(LITTLE_RIGHT, VEER_RIGHT);
    setSensors(1'b0, 1'b1, 1'b0);
    checkNav(STRAIGHT, FORWARD);
    checkStack(0, NONE);
    reportTest("driftTest", errorsBefore);
endtask

task automatic junctionTest();
    int errorsBefore;
    errorsBefore = errorCount;
    setSensors(1'b1, 1'b1, 1'b1);
    checkNav(CHOOSE, HALT);
    checkStack(1, DEC_STRAIGHT);
    setSensors(1'b1, 1'b0, 1'b1);
    checkNav(STOP, HALT);
    checkStack(1, DEC_LEFT);
    // Plain line under the robot so LEFT holds once reached
    setSensors(1'b0, 1'b1, 1'b0);
    waitForState(LEFT, stopCycles + 4);
    checkNav(LEFT, SPIN_LEFT);
    checkStack(1, DEC_LEFT);
    reportTest("junctionTest", errorsBefore);
endtask

task automatic deadEndTest();
    int errorsBefore;
    errorsBefore = errorCount;
    // Leave the left branch, then meet a fresh junction
    setSensors(1'b1, 1'b1, 1'b1);
    checkNav(STOP, HALT);
    waitForState(STRAIGHT, stopCycles + 4);
    setSensors(1'b0, 1'b1, 1'b0);
    setSensors(1'b1, 1'b1, 1'b1);
    checkNav(CHOOSE, HALT);
    checkStack(2, DEC_STRAIGHT);
    setSensors(1'b0, 1'b1, 1'b0);
    setSensors(1'b1, 1'b1, 1'b1);
    checkNav(STRAIGHT, FORWARD);

    // Line ends
    setSensors(1'b0, 1'b0, 1'b0);
    checkNav(STOP, HALT);
    waitForState(BACK, stopCycles + 4);
    checkNav(BACK, REVERSE);
    checkStack(2, DEC_STRAIGHT);
    setSensors(1'b1, 1'b1, 1'b1);
    checkNav(STOP, HALT);
    checkStack(2, DEC_LEFT);
    setSensors(1'b0, 1'b1, 1'b0);
    waitForState(LEFT, stopCycles + 4);
    checkNav(LEFT, SPIN_LEFT);
    reportTest("deadEndTest", errorsBefore);
endtask

task automatic finishTest();
    int errorsBefore;
    errorsBefore = errorCount;
    @(posedge clk);
    obstacleNear <= 1'b1;
    waitForState(FINISH, 4);
    checkNav(FINISH, HALT);
    @(posedge clk);
    enable       <= 1'b0;
    obstacleNear <= 1'b0;
    waitForState(IDLE, 4);
    checkNav(IDLE, HALT);
    reportTest("finishTest", errorsBefore);
endtask

`endif

// ==== tests/mazeControllerTb.sv ====
`default_nettype none

module mazeControllerTb;
    timeunit 1ns;
    timeprecision 1ps;

    import mazePkg::*;

    localparam int countCycles = 8;
    localparam int stopCycles  = 5;
    // All six tests together take well under 300 cycles
    localparam int cycleLimit  = 2000;

    logic                  clk;
    logic                  rst;
    logic                  enable;
    logic                  leftTrack;
    logic                  midTrack;
    logic                  rightTrack;
    logic                  obstacleNear;
    driveCmd_t             driveCmd;
    navState_t             navState;
    logic [depthWidth-1:0] stackDepth;
    decision_t             stackTop;

    int errorCount;
    int testCount;
    int failedTests;
    int cycleCount;

    mazeController #(
        .countCycles (countCycles),
        .stopCycles  (stopCycles),
        .stackSize   (50)
    ) u_dut (
        .clk          (clk),
        .rst          (rst),
        .enable       (enable),
        .leftTrack    (leftTrack),
        .midTrack     (midTrack),
        .rightTrack   (rightTrack),
        .obstacleNear (obstacleNear),
        .driveCmd     (driveCmd),
        .navState     (navState),
        .stackDepth   (stackDepth),
        .stackTop     (stackTop)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        cycleCount = 0;
        while (cycleCount < cycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
        $display("*** TEST FAILED ***");
        $finish;
    end

    // Sensor change needs three edges to reach navState, one more for the stack
    task automatic setSensors(input logic l, input logic m, input logic r);
        @(posedge clk);
        leftTrack  <= l;
        midTrack   <= m;
        rightTrack <= r;
        repeat (4) @(posedge clk);
        @(negedge clk);
    endtask

    task automatic checkNav(input navState_t expState, input driveCmd_t expCmd);
        if (navState !== expState) begin
            $display("FAILED at %0t ns: navState = %s, expected %s",
                     $time, navState.name(), expState.name());
            errorCount++;
        end
        if (driveCmd !== expCmd) begin
            $display("FAILED at %0t ns: driveCmd = %s, expected %s",
                     $time, driveCmd.name(), expCmd.name());
            errorCount++;
        end
    endtask

    task automatic checkStack(input int expDepth, input decision_t expTop);
        if (stackDepth !== depthWidth'(expDepth)) begin
            $display("FAILED at %0t ns: stackDepth = %0d, expected %0d",
                     $time, stackDepth, expDepth);
            errorCount++;
        end
        if (stackTop !== expTop) begin
            $display("FAILED at %0t ns: stackTop = %s, expected %s",
                     $time, stackTop.name(), expTop.name());
            errorCount++;
        end
    endtask

    task automatic waitForState(input navState_t target, input int bound);
        int waited;
        waited = 0;
        while (navState !== target && waited < bound) begin
            @(negedge clk);
            waited++;
        end
        if (navState !== target) begin
            $display("navState did not reach %s within %0d cycles", target.name(), bound);
            errorCount++;
        end
    endtask

    // Number of sampled cycles spent in one state
    task automatic measureStay(input navState_t target, output int cycles);
        cycles = 0;
        while (navState === target && cycles < cycleLimit) begin
            cycles++;
            @(negedge clk);
        end
    endtask

    task automatic reportTest(input string name, input int errorsBefore);
        testCount++;
        if (errorCount == errorsBefore) begin
            $display("%s: ok", name);
        end else begin
            failedTests++;
            $display("%s: %0d check(s) wrong", name, errorCount - errorsBefore);
        end
    endtask

    `include "mazeControllerTests.svh"

    initial begin
        errorCount   = 0;
        testCount    = 0;
        failedTests  = 0;
        rst          = 1'b1;
        enable       = 1'b0;
        leftTrack    = 1'b0;
        midTrack     = 1'b0;
        rightTrack   = 1'b0;
        obstacleNear = 1'b0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);

        resetTest();
        launchTest();
        driftTest();
        junctionTest();
        deadEndTest();
        finishTest();

        $display("Summary: %0d tests, %0d failed, %0d wrong checks",
                 testCount, failedTests, errorCount);
        if (errorCount == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== mazeController.f ====
+incdir+tests
hw/mazePkg.sv
hw/stackIf.sv
hw/trackDecoder.sv
hw/waitTimer.sv
hw/mazeNavigator.sv
hw/decisionStack.sv
hw/mazeController.sv
tests/mazeControllerTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module mazeControllerTb \
    -f mazeController.f \
    --Mdir obj_dir \
    -o mazeControllerSim

./obj_dir/mazeControllerSim | tee sim.log

if grep -qF "*** TEST FAILED ***" sim.log; then
    echo "Simulation reported a failure, see sim.log"
    exit 1
fi

echo "Simulation log is clean"
